//--- project.f
rtl/ecc_icn_pkg.sv
rtl/tcdm_intf.sv
rtl/tcdm_xbar.sv
rtl/bank_ecc_bridge.sv
rtl/ecc_err_manager.sv
rtl/ecc_icn_top.sv
dv/ecc_icn_sva.sv
dv/ecc_icn_tb.sv

//--- dv/ecc_icn_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_icn_tb import ecc_icn_pkg::*; ();

  localparam int unsigned SEED      = 32'h41c8_b42d;
  localparam int unsigned TIMEOUT   = 3000;      // Cycles well above the sum of all tests
  localparam int unsigned ROWS      = 256;

  logic                          clk_i;
  logic                          rst_ni;
  logic [N_INIT-1:0]             init_req;
  logic [N_INIT-1:0][ADDR_W-1:0] init_addr;
  logic [N_INIT-1:0]             init_wen;
  logic [N_INIT-1:0][DATA_W-1:0] init_wdata;
  logic [N_INIT-1:0]             init_gnt;
  logic [N_INIT-1:0]             init_r_valid;
  logic [N_INIT-1:0][DATA_W-1:0] init_r_rdata;
  logic [N_INIT-1:0]             init_r_err;
  logic [N_BANK-1:0]             bank_req;
  logic [N_BANK-1:0]             bank_we;
  logic [N_BANK-1:0][ROW_W-1:0]  bank_row;
  logic [N_BANK-1:0][CODE_W-1:0] bank_wdata;
  logic [N_BANK-1:0][CODE_W-1:0] bank_rdata;
  logic                          reg_req;
  logic                          reg_we;
  logic [REG_ADDR_W-1:0]         reg_addr;
  logic [DATA_W-1:0]             reg_wdata;
  logic                          reg_r_valid;
  logic [DATA_W-1:0]             reg_r_rdata;
  logic [CODE_W-1:0]             mem [N_BANK][ROWS];   // SRAM contents per bank
  int                            cycles;
  int                            errors;
  int                            tests_ok;
  int                            tests_bad;

  ecc_icn_top u_dut (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .init_req_i (init_req), .init_addr_i (init_addr), .init_wen_i (init_wen),
    .init_wdata_i (init_wdata), .init_gnt_o (init_gnt), .init_r_valid_o (init_r_valid),
    .init_r_rdata_o (init_r_rdata), .init_r_err_o (init_r_err),
    .bank_req_o (bank_req), .bank_we_o (bank_we), .bank_row_o (bank_row),
    .bank_wdata_o (bank_wdata), .bank_rdata_i (bank_rdata),
    .reg_req_i (reg_req), .reg_we_i (reg_we), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_r_valid_o (reg_r_valid), .reg_r_rdata_o (reg_r_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;                      // 40 ns period
  end

  // Banks accept every request and return read data one cycle later
  always @(posedge clk_i) begin
    for (int b = 0; b < N_BANK; b++) begin
      if (bank_req[b]) begin
        if (bank_we[b]) mem[b][bank_row[b]] <= bank_wdata[b];
        bank_rdata[b] <= mem[b][bank_row[b]];
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("Done: errors found");
      $finish;
    end
  end

  // Reference codeword from the XOR of the Hamming positions of all set data bits
  function automatic logic [CODE_W-1:0] ref_code(input logic [DATA_W-1:0] data);
    logic [5:0] syn;
    int         idx;
    syn = '0;
    idx = 0;
    for (int pos = 1; pos <= 38; pos++) begin
      if ((pos & (pos - 1)) != 0) begin              // Not a power of two
        if (data[idx]) syn = syn ^ 6'(pos);
        idx++;
      end
    end
    return {^{syn, data}, syn, data};                // Even parity over the codeword
  endfunction

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic test_done(input string name, input int err_before);
    if (errors == err_before) begin
      $display("PASS %s", name);
      tests_ok++;
    end else begin
      $display("FAIL %s", name);
      tests_bad++;
    end
  endtask

  task automatic flip_bits(input int b, input int row, input logic [CODE_W-1:0] mask);
    mem[b][row] = mem[b][row] ^ mask;
  endtask

  task automatic do_access(input int i, input logic [ADDR_W-1:0] addr, input logic wen,
                           input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                           output logic err, output int gcyc);
    logic g;
    @(posedge clk_i);
    #2;
    init_req[i]   = 1'b1;
    init_addr[i]  = addr;
    init_wen[i]   = wen;
    init_wdata[i] = wdata;
    g = 1'b0;
    while (!g) begin                                 // Hold until granted
      @(negedge clk_i);
      g = init_gnt[i];
      if (!g) @(posedge clk_i);
    end
    gcyc = cycles;
    @(posedge clk_i);
    #2;
    init_req[i] = 1'b0;
    @(negedge clk_i);
    if (!init_r_valid[i]) begin
      $display("At %0t initiator %0d got no response one cycle after its grant", $time, i);
      errors++;
    end
    rdata = init_r_rdata[i];
    err   = init_r_err[i];
  endtask

  task automatic write_word(input int i, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rd;
    logic              er;
    int                gc;
    do_access(i, addr, 1'b0, data, rd, er, gc);
  endtask

  task automatic read_expect(input int i, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] exp, input logic exp_err);
    logic [DATA_W-1:0] rd;
    logic              er;
    int                gc;
    do_access(i, addr, 1'b1, '0, rd, er, gc);
    if (!exp_err && rd != exp) value_error("init_r_rdata_o", rd, exp);
    if (er != exp_err) value_error("init_r_err_o", er, exp_err);
  endtask

  task automatic reg_access(input logic we, input logic [REG_ADDR_W-1:0] addr,
                            output logic [DATA_W-1:0] data);
    @(posedge clk_i);
    #2;
    reg_req  = 1'b1;
    reg_we   = we;
    reg_addr = addr;
    reg_wdata = 32'hffff_ffff;                       // Clear ignores the data
    @(posedge clk_i);
    #2;
    reg_req = 1'b0;
    @(negedge clk_i);
    if (!reg_r_valid) begin
      $display("At %0t the register port gave no response", $time);
      errors++;
    end
    data = reg_r_rdata;
  endtask

  task automatic test_contention();
    int                e0;
    int                g0;
    int                g1;
    logic [DATA_W-1:0] rd0;
    logic [DATA_W-1:0] rd1;
    logic              er0;
    logic              er1;
    e0 = errors;
    fork
      do_access(0, 12'h014, 1'b0, 32'hcafe_0001, rd0, er0, g0);   // Both aim at bank 1
      do_access(1, 12'h024, 1'b0, 32'hbeef_0002, rd1, er1, g1);
    join
    if (g1 != g0 + 1) value_error("grant cycle of initiator 1", g1, g0 + 1);
    fork
      do_access(0, 12'h014, 1'b1, '0, rd0, er0, g0);
      do_access(1, 12'h024, 1'b1, '0, rd1, er1, g1);
    join
    if (g1 != g0 + 1) value_error("second grant cycle of initiator 1", g1, g0 + 1);
    if (rd0 != 32'hcafe_0001) value_error("init_r_rdata_o[0]", rd0, 32'hcafe_0001);
    if (rd1 != 32'hbeef_0002) value_error("init_r_rdata_o[1]", rd1, 32'hbeef_0002);
    test_done("same-bank contention", e0);
  endtask

  task automatic test_rw_clean();
    int                e0;
    int                b;
    int                row;
    logic [DATA_W-1:0] data;
    e0 = errors;
    for (int n = 0; n < 16; n++) begin
      b    = n % N_BANK;
      row  = $urandom % ROWS;
      data = $urandom;
      write_word(n % N_INIT, {8'(row), 2'(b), 2'b00}, data);
      if (mem[b][row] != ref_code(data)) begin
        value_error("stored codeword", mem[b][row], ref_code(data));
      end
      read_expect((n + 1) % N_INIT, {8'(row), 2'(b), 2'b00}, data, 1'b0);
    end
    test_done("write and read back", e0);
  endtask

  task automatic test_parallel();
    int                e0;
    int                g0;
    int                g1;
    logic [DATA_W-1:0] rd0;
    logic [DATA_W-1:0] rd1;
    logic              er0;
    logic              er1;
    e0 = errors;
    write_word(0, 12'h300, 32'h1111_aaaa);           // Bank 0
    write_word(1, 12'h30c, 32'h2222_bbbb);           // Bank 3
    fork
      do_access(0, 12'h300, 1'b1, '0, rd0, er0, g0);
      do_access(1, 12'h30c, 1'b1, '0, rd1, er1, g1);
    join
    if (g0 != g1) value_error("grant cycle of initiator 1", g1, g0);
    if (rd0 != 32'h1111_aaaa) value_error("init_r_rdata_o[0]", rd0, 32'h1111_aaaa);
    if (rd1 != 32'h2222_bbbb) value_error("init_r_rdata_o[1]", rd1, 32'h2222_bbbb);
    test_done("parallel banks", e0);
  endtask

  task automatic test_single_fault();
    int                e0;
    int                pos [7] = '{0, 15, 31, 32, 35, 37, 38};   // Data, check, parity
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] c0;
    logic [DATA_W-1:0] c1;
    e0 = errors;
    reg_access(1'b0, REG_CORR_CNT, c0);
    for (int k = 0; k < 7; k++) begin
      data = $urandom;
      write_word(k % N_INIT, {8'(10 + k), 2'd2, 2'b00}, data);
      flip_bits(2, 10 + k, CODE_W'(1) << pos[k]);
      read_expect(k % N_INIT, {8'(10 + k), 2'd2, 2'b00}, data, 1'b0);
    end
    reg_access(1'b0, REG_CORR_CNT, c1);
    if (c1 != c0 + 7) value_error("correctable count", c1, c0 + 7);
    test_done("single-bit fault", e0);
  endtask

  task automatic test_double_fault();
    int                e0;
    int                pa [3] = '{1, 32, 38};
    int                pb [3] = '{30, 4, 36};
    logic [DATA_W-1:0] u0;
    logic [DATA_W-1:0] u1;
    logic [DATA_W-1:0] c0;
    logic [DATA_W-1:0] c1;
    logic [DATA_W-1:0] mask;
    e0 = errors;
    reg_access(1'b0, REG_UNCORR_CNT, u0);
    for (int k = 0; k < 3; k++) begin
      write_word(0, {8'(40 + k), 2'd3, 2'b00}, $urandom);
      flip_bits(3, 40 + k, (CODE_W'(1) << pa[k]) | (CODE_W'(1) << pb[k]));
      read_expect(1, {8'(40 + k), 2'd3, 2'b00}, '0, 1'b1);
    end
    reg_access(1'b0, REG_UNCORR_CNT, u1);
    if (u1 != u0 + 3) value_error("uncorrectable count", u1, u0 + 3);
    reg_access(1'b0, REG_UNCORR_BANKS, mask);
    if (mask != 32'h8) value_error("uncorrectable bank mask", mask, 32'h8);   // Only bank 3
    // Writing over faulty rows leaves the counters alone
    reg_access(1'b0, REG_CORR_CNT, c0);
    flip_bits(3, 40, 39'h3);
    write_word(1, {8'd40, 2'd3, 2'b00}, 32'h0bad_f00d);
    flip_bits(3, 41, CODE_W'(1) << pb[1]);           // Row 41 keeps a single fault
    write_word(0, {8'd41, 2'd3, 2'b00}, 32'h0bad_f00e);
    reg_access(1'b0, REG_CORR_CNT, c1);
    reg_access(1'b0, REG_UNCORR_CNT, u0);
    if (c1 != c0) value_error("correctable count after write", c1, c0);
    if (u0 != u1) value_error("uncorrectable count after write", u0, u1);
    test_done("double-bit fault", e0);
  endtask

  task automatic test_reg_clear();
    int                e0;
    logic [DATA_W-1:0] rd;
    logic [REG_ADDR_W-1:0] offs [3] = '{4'h0, 4'h4, 4'h8};
    e0 = errors;
    reg_access(1'b0, 4'hc, rd);                      // Counters still hold earlier faults
    if (rd != '0) value_error("reg_r_rdata_o at unmapped offset", rd, 0);
    for (int k = 0; k < 3; k++) begin
      reg_access(1'b1, offs[k], rd);
      if (rd != '0) value_error("reg_r_rdata_o on write", rd, 0);
    end
    for (int k = 0; k < 3; k++) begin
      reg_access(1'b0, offs[k], rd);
      if (rd != '0) value_error("reg_r_rdata_o after clear", rd, 0);
    end
    test_done("register clear", e0);
  endtask

  initial begin
    void'($urandom(SEED));
    cycles     = 0;
    errors     = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    rst_ni     = 1'b0;
    init_req   = '0;
    init_addr  = '0;
    init_wen   = '0;
    init_wdata = '0;
    bank_rdata = '0;
    reg_req    = 1'b0;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    for (int b = 0; b < N_BANK; b++) begin
      for (int r = 0; r < ROWS; r++) mem[b][r] = ref_code({22'h0, 2'(b), 8'(r)} ^ 32'h5a5a_0000);
    end
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    test_contention();                               // Needs fresh round-robin state
    test_rw_clean();
    test_parallel();
    test_single_fault();
    test_double_fault();
    test_reg_clear();
    $display("Tests passed %0d, failed %0d, check errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/ecc_icn_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_icn_sva import ecc_icn_pkg::*; (
  input wire logic              clk_i,
  input wire logic              rst_ni,
  input wire logic [N_INIT-1:0] init_req_i,
  input wire logic [N_INIT-1:0] init_gnt_o,
  input wire logic [N_INIT-1:0] init_r_valid_o,
  input wire logic              reg_req_i,
  input wire logic              reg_r_valid_o
);

  for (genvar i = 0; i < N_INIT; i++) begin : gen_init
    a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      init_gnt_o[i] |-> init_req_i[i]) else $error("Grant without request on %0d", i);
    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (init_req_i[i] && init_gnt_o[i]) |=> init_r_valid_o[i])
      else $error("Missing response on %0d", i);
    a_rvalid_only_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      init_r_valid_o[i] |-> $past(init_req_i[i] && init_gnt_o[i]))
      else $error("Response without grant on %0d", i);
  end

  a_reg_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_req_i |=> reg_r_valid_o) else $error("Register response missing");

endmodule

bind ecc_icn_top ecc_icn_sva u_sva (.*);

`default_nettype wire

//--- rtl/ecc_icn_top.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_icn_top import ecc_icn_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Initiator ports
  input  logic [N_INIT-1:0]             init_req_i,
  input  logic [N_INIT-1:0][ADDR_W-1:0] init_addr_i,
  input  logic [N_INIT-1:0]             init_wen_i,
  input  logic [N_INIT-1:0][DATA_W-1:0] init_wdata_i,
  output logic [N_INIT-1:0]             init_gnt_o,
  output logic [N_INIT-1:0]             init_r_valid_o,
  output logic [N_INIT-1:0][DATA_W-1:0] init_r_rdata_o,
  output logic [N_INIT-1:0]             init_r_err_o,
  // SRAM banks, codewords in and out
  output logic [N_BANK-1:0]             bank_req_o,
  output logic [N_BANK-1:0]             bank_we_o,
  output logic [N_BANK-1:0][ROW_W-1:0]  bank_row_o,
  output logic [N_BANK-1:0][CODE_W-1:0] bank_wdata_o,
  input  logic [N_BANK-1:0][CODE_W-1:0] bank_rdata_i,
  // Error register port
  input  logic                          reg_req_i,
  input  logic                          reg_we_i,
  input  logic [REG_ADDR_W-1:0]         reg_addr_i,
  input  logic [DATA_W-1:0]             reg_wdata_i,
  output logic                          reg_r_valid_o,
  output logic [DATA_W-1:0]             reg_r_rdata_o
);

  logic [N_BANK-1:0] corr_err;
  logic [N_BANK-1:0] uncorr_err;

  tcdm_intf bank_if [N_BANK] ();      // Crossbar to ECC bridge

  tcdm_xbar u_xbar (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .init_req_i     ( init_req_i     ),
    .init_addr_i    ( init_addr_i    ),
    .init_wen_i     ( init_wen_i     ),
    .init_wdata_i   ( init_wdata_i   ),
    .init_gnt_o     ( init_gnt_o     ),
    .init_r_valid_o ( init_r_valid_o ),
    .init_r_rdata_o ( init_r_rdata_o ),
    .init_r_err_o   ( init_r_err_o   ),
    .bank           ( bank_if        )
  );

  for (genvar b = 0; b < N_BANK; b++) begin : gen_bridge
    bank_ecc_bridge u_bridge (
      .clk_i        ( clk_i           ),
      .rst_ni       ( rst_ni          ),
      .xbar         ( bank_if[b]      ),
      .bank_req_o   ( bank_req_o[b]   ),
      .bank_we_o    ( bank_we_o[b]    ),
      .bank_row_o   ( bank_row_o[b]   ),
      .bank_wdata_o ( bank_wdata_o[b] ),
      .bank_rdata_i ( bank_rdata_i[b] ),
      .corr_err_o   ( corr_err[b]     ),
      .uncorr_err_o ( uncorr_err[b]   )
    );
  end

  ecc_err_manager u_err_manager (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .corr_err_i    ( corr_err      ),
    .uncorr_err_i  ( uncorr_err    ),
    .reg_req_i     ( reg_req_i     ),
    .reg_we_i      ( reg_we_i      ),
    .reg_addr_i    ( reg_addr_i    ),
    .reg_wdata_i   ( reg_wdata_i   ),
    .reg_r_valid_o ( reg_r_valid_o ),
    .reg_r_rdata_o ( reg_r_rdata_o )
  );

endmodule

`default_nettype wire

//--- rtl/ecc_err_manager.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_err_manager import ecc_icn_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [N_BANK-1:0]     corr_err_i,
  input  logic [N_BANK-1:0]     uncorr_err_i,
  input  logic                  reg_req_i,
  input  logic                  reg_we_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [DATA_W-1:0]     reg_wdata_i,
  output logic                  reg_r_valid_o,
  output logic [DATA_W-1:0]     reg_r_rdata_o
);

  logic [DATA_W-1:0] corr_cnt_q;
  logic [DATA_W-1:0] uncorr_cnt_q;
  logic [N_BANK-1:0] uncorr_mask_q;     // Sticky per bank
  logic [DATA_W:0]   corr_sum;          // One extra bit for overflow
  logic [DATA_W:0]   uncorr_sum;
  logic              reg_wr;
  logic              reg_rd;
  logic [DATA_W-1:0] rd_mux;

  assign reg_wr = reg_req_i && reg_we_i;
  assign reg_rd = reg_req_i && !reg_we_i;

  // Add the number of flagged banks to each counter
  always_comb begin
    corr_sum   = {1'b0, corr_cnt_q};
    uncorr_sum = {1'b0, uncorr_cnt_q};
    for (int unsigned b = 0; b < N_BANK; b++) begin
      corr_sum   = corr_sum + (DATA_W + 1)'(corr_err_i[b]);
      uncorr_sum = uncorr_sum + (DATA_W + 1)'(uncorr_err_i[b]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      corr_cnt_q    <= '0;
      uncorr_cnt_q  <= '0;
      uncorr_mask_q <= '0;
    end else begin
      // Any write to an offset clears it, data is ignored
      if (reg_wr && (reg_addr_i == REG_CORR_CNT)) begin
        corr_cnt_q <= '0;
      end else begin
        corr_cnt_q <= corr_sum[DATA_W] ? '1 : corr_sum[DATA_W-1:0];   // Saturate
      end
      if (reg_wr && (reg_addr_i == REG_UNCORR_CNT)) begin
        uncorr_cnt_q <= '0;
      end else begin
        uncorr_cnt_q <= uncorr_sum[DATA_W] ? '1 : uncorr_sum[DATA_W-1:0];
      end
      if (reg_wr && (reg_addr_i == REG_UNCORR_BANKS)) begin
        uncorr_mask_q <= '0;
      end else begin
        uncorr_mask_q <= uncorr_mask_q | uncorr_err_i;
      end
    end
  end

  always_comb begin
    case (reg_addr_i)
      REG_CORR_CNT:     rd_mux = corr_cnt_q;
      REG_UNCORR_CNT:   rd_mux = uncorr_cnt_q;
      REG_UNCORR_BANKS: rd_mux = DATA_W'(uncorr_mask_q);
      default:          rd_mux = '0;              // Unmapped reads as zero
    endcase
  end

  // Response one cycle after every request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_r_valid_o <= 1'b0;
      reg_r_rdata_o <= '0;
    end else begin
      reg_r_valid_o <= reg_req_i;
      reg_r_rdata_o <= reg_rd ? rd_mux : '0;       // Zero for writes
    end
  end

endmodule

`default_nettype wire

//--- rtl/bank_ecc_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module bank_ecc_bridge import ecc_icn_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  tcdm_intf.target          xbar,
  output logic              bank_req_o,
  output logic              bank_we_o,
  output logic [ROW_W-1:0]  bank_row_o,
  output logic [CODE_W-1:0] bank_wdata_o,
  input  logic [CODE_W-1:0] bank_rdata_i,
  output logic              corr_err_o,
  output logic              uncorr_err_o
);

  logic              xfer;          // Transfer on this edge
  logic              valid_q;       // Any access in flight
  logic              read_q;        // Read in flight
  logic [DATA_W-1:0] dec_data;
  logic              dec_single;
  logic              dec_multi;

  // Bank never stalls
  assign xbar.gnt = xbar.req;
  assign xfer     = xbar.req && xbar.gnt;

  assign bank_req_o   = xbar.req;
  assign bank_we_o    = xbar.req && !xbar.wen;        // Full-word writes only
  assign bank_row_o   = xbar.addr;
  assign bank_wdata_o = secded_encode(xbar.wdata);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      read_q  <= 1'b0;
    end else begin
      valid_q <= xfer;
      read_q  <= xfer && xbar.wen;
    end
  end

  // Decode straight off the bank in the response cycle
  always_comb begin
    secded_decode(bank_rdata_i, dec_data, dec_single, dec_multi);
  end

  assign xbar.r_valid = valid_q;
  assign xbar.r_rdata = read_q ? dec_data : '0;       // Writes answer with zero
  assign xbar.r_err   = read_q && dec_multi;

  // Stale bank data on idle cycles must not count
  assign corr_err_o   = read_q && dec_single;
  assign uncorr_err_o = read_q && dec_multi;

endmodule

`default_nettype wire

//--- rtl/tcdm_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module tcdm_xbar import ecc_icn_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [N_INIT-1:0]             init_req_i,
  input  logic [N_INIT-1:0][ADDR_W-1:0] init_addr_i,
  input  logic [N_INIT-1:0]             init_wen_i,
  input  logic [N_INIT-1:0][DATA_W-1:0] init_wdata_i,
  output logic [N_INIT-1:0]             init_gnt_o,
  output logic [N_INIT-1:0]             init_r_valid_o,
  output logic [N_INIT-1:0][DATA_W-1:0] init_r_rdata_o,
  output logic [N_INIT-1:0]             init_r_err_o,
  tcdm_intf.initiator                   bank [N_BANK]
);

  logic [N_INIT-1:0][BANK_SEL_W-1:0] bank_sel;     // Target bank per initiator
  logic [N_BANK-1:0][N_INIT-1:0]     want;         // Contenders per bank
  logic [N_BANK-1:0][N_INIT-1:0]     bank_win;     // One-hot winner per bank
  logic [N_BANK-1:0][INIT_IDX_W-1:0] bank_route;   // Owner of the response
  logic [N_BANK-1:0]                 bank_gnt;
  logic [N_BANK-1:0]                 bank_rvalid;
  logic [N_BANK-1:0]                 bank_rerr;
  logic [N_BANK-1:0][DATA_W-1:0]     bank_rdata;

  // Bank decode on address bits 3:2
  always_comb begin
    for (int unsigned i = 0; i < N_INIT; i++) begin
      bank_sel[i] = init_addr_i[i][ROW_LSB-1:BANK_LSB];
    end
    for (int unsigned b = 0; b < N_BANK; b++) begin
      for (int unsigned i = 0; i < N_INIT; i++) begin
        want[b][i] = init_req_i[i] && (bank_sel[i] == BANK_SEL_W'(b));
      end
    end
  end

  for (genvar b = 0; b < N_BANK; b++) begin : gen_bank
    logic [N_INIT-1:0]     win;
    logic [INIT_IDX_W-1:0] win_idx;
    logic [INIT_IDX_W-1:0] last_q;                    // Last granted, routes the response

    // Round-robin, search starts just after the last winner
    always_comb begin
      logic        found;
      int unsigned cand;
      found   = 1'b0;
      win     = '0;
      win_idx = last_q;
      for (int unsigned k = 1; k <= N_INIT; k++) begin
        cand = (int'(last_q) + k) % N_INIT;
        if (!found && want[b][cand]) begin
          found     = 1'b1;
          win[cand] = 1'b1;
          win_idx   = INIT_IDX_W'(cand);
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        last_q <= INIT_IDX_W'(N_INIT - 1);            // Initiator 0 first after reset
      end else if (bank[b].req && bank[b].gnt) begin
        last_q <= win_idx;
      end
    end

    assign bank[b].req   = |want[b];
    assign bank[b].addr  = init_addr_i[win_idx][ROW_LSB+:ROW_W];
    assign bank[b].wen   = init_wen_i[win_idx];
    assign bank[b].wdata = init_wdata_i[win_idx];

    assign bank_win[b]    = win;
    assign bank_route[b]  = last_q;
    assign bank_gnt[b]    = bank[b].gnt;
    assign bank_rvalid[b] = bank[b].r_valid;
    assign bank_rdata[b]  = bank[b].r_rdata;
    assign bank_rerr[b]   = bank[b].r_err;
  end

  // Grants back to initiators, responses steered by the stored owner
  always_comb begin
    init_gnt_o     = '0;
    init_r_valid_o = '0;
    init_r_rdata_o = '0;
    init_r_err_o   = '0;
    for (int unsigned i = 0; i < N_INIT; i++) begin
      for (int unsigned b = 0; b < N_BANK; b++) begin
        if (bank_win[b][i] && bank_gnt[b]) begin
          init_gnt_o[i] = 1'b1;
        end
        if (bank_rvalid[b] && (bank_route[b] == INIT_IDX_W'(i))) begin
          init_r_valid_o[i] = 1'b1;                   // At most one bank per initiator
          init_r_rdata_o[i] = bank_rdata[b];
          init_r_err_o[i]   = bank_rerr[b];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/tcdm_intf.sv
`timescale 1ns/1ps
`default_nettype none

interface tcdm_intf import ecc_icn_pkg::*; ();

  logic              req;
  logic              gnt;
  logic [ROW_W-1:0]  addr;      // Row inside the bank
  logic              wen;       // High for read
  logic [DATA_W-1:0] wdata;
  logic              r_valid;   // One cycle after the grant
  logic [DATA_W-1:0] r_rdata;
  logic              r_err;     // Uncorrectable read

  modport initiator (
    output req, addr, wen, wdata,
    input  gnt, r_valid, r_rdata, r_err
  );

  modport target (
    input  req, addr, wen, wdata,
    output gnt, r_valid, r_rdata, r_err
  );

endinterface

`default_nettype wire

//--- rtl/ecc_icn_pkg.sv
`default_nettype none

package ecc_icn_pkg;

  localparam int unsigned N_INIT     = 2;                    // Initiator ports
  localparam int unsigned N_BANK     = 4;                    // Memory banks
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned CHECK_W    = 7;                    // Hamming bits plus overall parity
  localparam int unsigned CODE_W     = DATA_W + CHECK_W;     // Stored codeword
  localparam int unsigned HAM_W      = CHECK_W - 1;          // Hamming bits only
  localparam int unsigned HAM_N      = DATA_W + HAM_W;       // Last Hamming position
  localparam int unsigned ADDR_W     = 12;                   // Byte address
  localparam int unsigned BANK_LSB   = 2;                    // Word interleaving
  localparam int unsigned BANK_SEL_W = 2;
  localparam int unsigned ROW_LSB    = BANK_LSB + BANK_SEL_W;
  localparam int unsigned ROW_W      = 8;
  localparam int unsigned INIT_IDX_W = 1;
  localparam int unsigned REG_ADDR_W = 4;

  localparam logic [REG_ADDR_W-1:0] REG_CORR_CNT     = 4'h0;
  localparam logic [REG_ADDR_W-1:0] REG_UNCORR_CNT   = 4'h4;
  localparam logic [REG_ADDR_W-1:0] REG_UNCORR_BANKS = 4'h8;

  // Data bits fill the non power of two positions 1..HAM_N in order
  function automatic logic [HAM_W-1:0] secded_hamming(input logic [DATA_W-1:0] data);
    logic [HAM_W-1:0] chk;
    int unsigned      idx;
    chk = '0;
    idx = 0;
    for (int unsigned pos = 1; pos <= HAM_N; pos++) begin
      if ((pos & (pos - 1)) != 0) begin                       // Skip check positions
        for (int unsigned k = 0; k < HAM_W; k++) begin
          if (pos[k]) chk[k] = chk[k] ^ data[idx];           // Bit k covers this position
        end
        idx++;
      end
    end
    return chk;
  endfunction

  function automatic logic [CODE_W-1:0] secded_encode(input logic [DATA_W-1:0] data);
    logic [HAM_W-1:0] chk;
    chk = secded_hamming(data);
    return {^{chk, data}, chk, data};                         // Parity on top, then check, data
  endfunction

  function automatic void secded_decode(
    input  logic [CODE_W-1:0] code,
    output logic [DATA_W-1:0] data,
    output logic              single_err,
    output logic              multi_err
  );
    logic [HAM_W-1:0] syndrome;
    logic             parity;
    int unsigned      idx;
    data     = code[DATA_W-1:0];
    syndrome = secded_hamming(data) ^ code[DATA_W+:HAM_W];
    parity   = ^code;                                         // Odd means one flipped bit
    idx      = 0;
    for (int unsigned pos = 1; pos <= HAM_N; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        if (parity && (syndrome == HAM_W'(pos))) data[idx] = ~data[idx];  // Flip bad bit
        idx++;
      end
    end
    // Syndrome past the last position cannot come from one flip
    single_err = parity && (syndrome <= HAM_W'(HAM_N));
    multi_err  = (!parity && (syndrome != '0)) || (parity && (syndrome > HAM_W'(HAM_N)));
  endfunction

endpackage

`default_nettype wire
